//--- common/rv_ctrl_pkg.sv
// Execute control encodings
// Types of the controls the decode stage hands to execute

package rv_ctrl_pkg;

	typedef enum logic [3:0] {
		ALUOP_ADD = 4'd0,
		ALUOP_SUB = 4'd1,
		ALUOP_SLL = 4'd2,
		ALUOP_LT  = 4'd3,
		ALUOP_LTU = 4'd4,
		ALUOP_XOR = 4'd5,
		ALUOP_SRL = 4'd6,
		ALUOP_SRA = 4'd7,
		ALUOP_OR  = 4'd8,
		ALUOP_AND = 4'd9,
		// Passes operand b, used for LUI and store data
		ALUOP_RS2 = 4'd10
	} alu_op_t;

	typedef enum logic {
		ALUSRCA_RS1 = 1'b0,
		ALUSRCA_PC  = 1'b1
	} alu_src_a_t;

	typedef enum logic {
		ALUSRCB_RS2 = 1'b0,
		ALUSRCB_IMM = 1'b1
	} alu_src_b_t;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'd0,
		MEMOP_LB   = 4'd1,
		MEMOP_LH   = 4'd2,
		MEMOP_LW   = 4'd3,
		MEMOP_LBU  = 4'd4,
		MEMOP_LHU  = 4'd5,
		MEMOP_SB   = 4'd6,
		MEMOP_SH   = 4'd7,
		MEMOP_SW   = 4'd8
	} mem_op_t;

	// Taken test on the ALU result
	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'd0,
		BCOND_ZERO   = 2'd1,
		BCOND_NZERO  = 2'd2,
		BCOND_ALWAYS = 2'd3
	} branch_cond_t;

	typedef enum logic [2:0] {
		EXCEPT_NONE          = 3'd0,
		EXCEPT_INSTR_FAULT   = 3'd1,
		EXCEPT_INSTR_ILLEGAL = 3'd2,
		EXCEPT_ECALL         = 3'd3,
		EXCEPT_EBREAK        = 3'd4
	} except_t;

endpackage

//--- common/rv_decode_params.svh
// Decode stage parameters
// Widths, queue depth and reset vector of the RV32I decode stage

`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// Register file address width
`define RV_REGADDR_W 5

// Fetched words held between fetch and decode
`define RV_QUEUE_DEPTH 4

// First PC after reset
`define RV_RESET_VECTOR 32'h0000_0000

`endif

//--- common/rv_isa_pkg.sv
// RV32I instruction set encodings
// Major opcodes and the funct3 codes the decoder looks at

package rv_isa_pkg;

	// Bits 6:0 of a 32-bit instruction, low two bits always 11
	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_OP_IMM   = 7'b0010011,
		OPC_AUIPC    = 7'b0010111,
		OPC_STORE    = 7'b0100011,
		OPC_OP       = 7'b0110011,
		OPC_LUI      = 7'b0110111,
		OPC_BRANCH   = 7'b1100011,
		OPC_JALR     = 7'b1100111,
		OPC_JAL      = 7'b1101111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_t;

	// Register and immediate ALU operations
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'd0, F3_SLL = 3'd1, F3_SLT = 3'd2, F3_SLTU = 3'd3,
		F3_XOR     = 3'd4, F3_SRL_SRA = 3'd5, F3_OR = 3'd6, F3_AND = 3'd7
	} f3_alu_t;

	// Conditional branches, 2 and 3 are reserved
	typedef enum logic [2:0] {
		F3_BEQ  = 3'd0, F3_BNE  = 3'd1, F3_BLT  = 3'd4,
		F3_BGE  = 3'd5, F3_BLTU = 3'd6, F3_BGEU = 3'd7
	} f3_branch_t;

	// Load and store access size, stores use only B, H and W
	typedef enum logic [2:0] {
		F3_B = 3'd0, F3_H = 3'd1, F3_W = 3'd2, F3_BU = 3'd4, F3_HU = 3'd5
	} f3_mem_t;

endpackage

//--- decode/decode_register.sv
// Decode register
// Tracks the PC, pops the queue and holds the controls shown to execute

`timescale 1ns/100ps

`include "rv_decode_params.svh"

module decode_register
	import rv_ctrl_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      q_instr_vld_i,
	input  logic                      q_err_i,
	input  logic                      x_stall_i,
	input  logic                      jump_i,
	input  logic [`RV_XLEN-1:0]       jump_target_i,
	input  logic [`RV_REGADDR_W-1:0]  rs1_i,
	input  logic [`RV_REGADDR_W-1:0]  rs2_i,
	input  logic [`RV_REGADDR_W-1:0]  rd_i,
	input  logic [`RV_XLEN-1:0]       imm_i,
	input  alu_op_t                   alu_op_i,
	input  alu_src_a_t                alu_src_a_i,
	input  alu_src_b_t                alu_src_b_i,
	input  mem_op_t                   mem_op_i,
	input  branch_cond_t              branch_cond_i,
	input  logic [`RV_XLEN-1:0]       addr_offs_i,
	input  logic                      addr_is_regoffs_i,
	input  except_t                   except_i,
	input  logic                      illegal_i,
	output logic                      q_pop_o,
	output logic                      d_vld_o,
	output logic [`RV_XLEN-1:0]       d_pc_o,
	output logic [`RV_REGADDR_W-1:0]  d_rs1_o,
	output logic [`RV_REGADDR_W-1:0]  d_rs2_o,
	output logic [`RV_REGADDR_W-1:0]  d_rd_o,
	output logic [`RV_XLEN-1:0]       d_imm_o,
	output alu_op_t                   d_alu_op_o,
	output alu_src_a_t                d_alu_src_a_o,
	output alu_src_b_t                d_alu_src_b_o,
	output mem_op_t                   d_mem_op_o,
	output branch_cond_t              d_branch_cond_o,
	output logic [`RV_XLEN-1:0]       d_addr_offs_o,
	output logic                      d_addr_is_regoffs_o,
	output except_t                   d_except_o
);

// Address of the word at the queue head
logic [`RV_XLEN-1:0] pc;
// Register holds a word execute has not yet taken
logic                full;
logic                squash;

assign q_pop_o = q_instr_vld_i && !x_stall_i && !jump_i;
assign squash  = q_err_i || illegal_i;
assign d_vld_o = full && !x_stall_i && !jump_i;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc              <= `RV_RESET_VECTOR;
		full            <= 1'b0;
		d_pc_o          <= `RV_RESET_VECTOR;
		d_mem_op_o      <= MEMOP_NONE;
		d_branch_cond_o <= BCOND_NEVER;
		d_except_o      <= EXCEPT_NONE;
	end else begin
		if (jump_i)
			pc <= jump_target_i;
		else if (q_pop_o)
			pc <= pc + `RV_XLEN'(4);
		// An unstalled cycle hands the shown word to execute
		if (jump_i)
			full <= 1'b0;
		else if (q_pop_o)
			full <= 1'b1;
		else if (!x_stall_i)
			full <= 1'b0;
		if (q_pop_o) begin
			d_pc_o          <= pc;
			d_mem_op_o      <= squash ? MEMOP_NONE : mem_op_i;
			d_branch_cond_o <= squash ? BCOND_NEVER : branch_cond_i;
			// Bus fault wins over an illegal encoding
			if (q_err_i)
				d_except_o <= EXCEPT_INSTR_FAULT;
			else if (illegal_i)
				d_except_o <= EXCEPT_INSTR_ILLEGAL;
			else
				d_except_o <= except_i;
		end
	end
end

always_ff @(posedge clk) begin
	if (q_pop_o) begin
		d_rs1_o             <= squash ? '0 : rs1_i;
		d_rs2_o             <= squash ? '0 : rs2_i;
		d_rd_o              <= squash ? '0 : rd_i;
		d_imm_o             <= imm_i;
		d_alu_op_o          <= alu_op_i;
		d_alu_src_a_o       <= alu_src_a_i;
		d_alu_src_b_o       <= alu_src_b_i;
		d_addr_offs_o       <= addr_offs_i;
		d_addr_is_regoffs_o <= addr_is_regoffs_i;
	end
end

// Memory access and exception never reach execute together
assert property (@(posedge clk) disable iff (!rst_n)
	d_vld_o |-> (d_mem_op_o == MEMOP_NONE || d_except_o == EXCEPT_NONE))
	else $error("decode_register: memory op issued with an exception");

endmodule

//--- decode/decode_table.sv
// RV32I decode table
// Maps one instruction word onto execute controls, purely combinational

`timescale 1ns/100ps

`include "rv_decode_params.svh"

module decode_table
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  logic [`RV_XLEN-1:0]      instr_i,
	output logic [`RV_REGADDR_W-1:0] rs1_o,
	output logic [`RV_REGADDR_W-1:0] rs2_o,
	output logic [`RV_REGADDR_W-1:0] rd_o,
	output logic [`RV_XLEN-1:0]      imm_o,
	output alu_op_t                  alu_op_o,
	output alu_src_a_t               alu_src_a_o,
	output alu_src_b_t               alu_src_b_o,
	output mem_op_t                  mem_op_o,
	output branch_cond_t             branch_cond_o,
	output logic [`RV_XLEN-1:0]      addr_offs_o,
	output logic                     addr_is_regoffs_o,
	output except_t                  except_o,
	output logic                     illegal_o
);

localparam logic [`RV_REGADDR_W-1:0] X0 = '0;

function automatic alu_op_t alu_op_of(input f3_alu_t f3, input logic alt);
	case (f3)
	F3_ADD_SUB: alu_op_of = alt ? ALUOP_SUB : ALUOP_ADD;
	F3_SLL:     alu_op_of = ALUOP_SLL;
	F3_SLT:     alu_op_of = ALUOP_LT;
	F3_SLTU:    alu_op_of = ALUOP_LTU;
	F3_XOR:     alu_op_of = ALUOP_XOR;
	F3_SRL_SRA: alu_op_of = alt ? ALUOP_SRA : ALUOP_SRL;
	F3_OR:      alu_op_of = ALUOP_OR;
	F3_AND:     alu_op_of = ALUOP_AND;
	endcase
endfunction

opcode_t             opcode;
logic [2:0]          funct3;
logic [6:0]          funct7;
f3_alu_t             f3_alu;
f3_branch_t          f3_br;
f3_mem_t             f3_mem;
logic                alt_ok;
logic [`RV_XLEN-1:0] imm_i_fmt;
logic [`RV_XLEN-1:0] imm_s_fmt;
logic [`RV_XLEN-1:0] imm_b_fmt;
logic [`RV_XLEN-1:0] imm_u_fmt;
logic [`RV_XLEN-1:0] imm_j_fmt;

assign opcode = opcode_t'(instr_i[6:0]);
assign funct3 = instr_i[14:12];
assign funct7 = instr_i[31:25];
assign f3_alu = f3_alu_t'(funct3);
assign f3_br  = f3_branch_t'(funct3);
assign f3_mem = f3_mem_t'(funct3);

// Only SUB and SRA/SRAI may set bit 30 of funct7
assign alt_ok = funct7 == 7'b0100000 && (f3_alu == F3_ADD_SUB || f3_alu == F3_SRL_SRA);

// ----------------------------------------------------------
// Immediate formats

assign imm_i_fmt = {{21{instr_i[31]}}, instr_i[30:20]};
assign imm_s_fmt = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
assign imm_b_fmt = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
assign imm_u_fmt = {instr_i[31:12], 12'h000};
assign imm_j_fmt = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

always_comb begin
	case (opcode)
	OPC_JAL:    addr_offs_o = imm_j_fmt;
	OPC_BRANCH: addr_offs_o = imm_b_fmt;
	OPC_STORE:  addr_offs_o = imm_s_fmt;
	OPC_JALR:   addr_offs_o = imm_i_fmt;
	OPC_LOAD:   addr_offs_o = imm_i_fmt;
	default:    addr_offs_o = '0;
	endcase
end

// ----------------------------------------------------------
// Execute controls

always_comb begin
	rs1_o             = instr_i[19:15];
	rs2_o             = instr_i[24:20];
	rd_o              = instr_i[11:7];
	imm_o             = imm_i_fmt;
	alu_op_o          = ALUOP_ADD;
	alu_src_a_o       = ALUSRCA_RS1;
	alu_src_b_o       = ALUSRCB_RS2;
	mem_op_o          = MEMOP_NONE;
	branch_cond_o     = BCOND_NEVER;
	addr_is_regoffs_o = 1'b0;
	except_o          = EXCEPT_NONE;
	illegal_o         = 1'b0;

	case (opcode)
	OPC_OP: begin
		alu_op_o  = alu_op_of(f3_alu, instr_i[30]);
		illegal_o = !(funct7 == 7'd0 || alt_ok);
	end
	OPC_OP_IMM: begin
		rs2_o       = X0;
		alu_src_b_o = ALUSRCB_IMM;
		alu_op_o    = alu_op_of(f3_alu, instr_i[30] && f3_alu == F3_SRL_SRA);
		if (f3_alu == F3_SLL || f3_alu == F3_SRL_SRA)
			illegal_o = !(funct7 == 7'd0 || alt_ok);
	end
	OPC_LUI, OPC_AUIPC: begin
		rs1_o       = X0;
		rs2_o       = X0;
		imm_o       = imm_u_fmt;
		alu_src_b_o = ALUSRCB_IMM;
		if (opcode == OPC_LUI)
			alu_op_o = ALUOP_RS2;
		else
			alu_src_a_o = ALUSRCA_PC;
	end
	OPC_JAL, OPC_JALR: begin
		// Link value PC+4 goes through the ALU
		rs2_o         = X0;
		imm_o         = `RV_XLEN'(4);
		alu_src_a_o   = ALUSRCA_PC;
		alu_src_b_o   = ALUSRCB_IMM;
		branch_cond_o = BCOND_ALWAYS;
		if (opcode == OPC_JAL) begin
			rs1_o = X0;
		end else begin
			addr_is_regoffs_o = 1'b1;
			illegal_o         = funct3 != 3'd0;
		end
	end
	OPC_BRANCH: begin
		rd_o = X0;
		// BNE, BLT and BLTU take on a nonzero result
		branch_cond_o = (funct3[0] ^ funct3[2]) ? BCOND_NZERO : BCOND_ZERO;
		case (f3_br)
		F3_BEQ, F3_BNE:   alu_op_o = ALUOP_SUB;
		F3_BLT, F3_BGE:   alu_op_o = ALUOP_LT;
		F3_BLTU, F3_BGEU: alu_op_o = ALUOP_LTU;
		default:          illegal_o = 1'b1;
		endcase
	end
	OPC_LOAD: begin
		rs2_o             = X0;
		addr_is_regoffs_o = 1'b1;
		case (f3_mem)
		F3_B:    mem_op_o = MEMOP_LB;
		F3_H:    mem_op_o = MEMOP_LH;
		F3_W:    mem_op_o = MEMOP_LW;
		F3_BU:   mem_op_o = MEMOP_LBU;
		F3_HU:   mem_op_o = MEMOP_LHU;
		default: illegal_o = 1'b1;
		endcase
	end
	OPC_STORE: begin
		rd_o              = X0;
		alu_op_o          = ALUOP_RS2;
		addr_is_regoffs_o = 1'b1;
		case (f3_mem)
		F3_B:    mem_op_o = MEMOP_SB;
		F3_H:    mem_op_o = MEMOP_SH;
		F3_W:    mem_op_o = MEMOP_SW;
		default: illegal_o = 1'b1;
		endcase
	end
	OPC_MISC_MEM: begin
		// FENCE orders nothing in this core
		rs1_o     = X0;
		rs2_o     = X0;
		rd_o      = X0;
		illegal_o = funct3 != 3'd0;
	end
	OPC_SYSTEM: begin
		rs1_o = X0;
		rs2_o = X0;
		rd_o  = X0;
		if (instr_i[19:7] == 13'd0 && instr_i[31:21] == 11'd0)
			except_o = instr_i[20] ? EXCEPT_EBREAK : EXCEPT_ECALL;
		else
			illegal_o = 1'b1;
	end
	default: illegal_o = 1'b1;
	endcase
end

endmodule

//--- decode/instr_queue.sv
// Instruction queue
// Circular buffer of fetched words and their bus error bits

`timescale 1ns/100ps

`include "rv_decode_params.svh"

module instr_queue #(
	parameter int DEPTH = `RV_QUEUE_DEPTH
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push_i,
	input  logic [`RV_XLEN-1:0] instr_i,
	input  logic                err_i,
	input  logic                pop_i,
	input  logic                flush_i,
	output logic [`RV_XLEN-1:0] head_instr_o,
	output logic                head_err_o,
	output logic                head_vld_o
);

localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

logic [`RV_XLEN-1:0] mem_instr [DEPTH];
logic                mem_err   [DEPTH];
logic [PTR_W-1:0]    wr_ptr;
logic [PTR_W-1:0]    rd_ptr;
logic [CNT_W-1:0]    count;
logic                full;

assign full = count == CNT_W'(DEPTH);

always_ff @(posedge clk) begin
	if (push_i) begin
		mem_instr[wr_ptr] <= instr_i;
		mem_err[wr_ptr]   <= err_i;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (push_i)
			wr_ptr <= wr_ptr + 1'b1;
		// Flush drops the old stream, a word pushed now starts the new one
		if (flush_i) begin
			rd_ptr <= wr_ptr;
			count  <= CNT_W'(push_i);
		end else begin
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
		end
	end
end

assign head_instr_o = mem_instr[rd_ptr];
assign head_err_o   = mem_err[rd_ptr];
assign head_vld_o   = count != '0;

// Fetch keeps at most DEPTH words outstanding
assert property (@(posedge clk) disable iff (!rst_n) (push_i && full) |-> (pop_i || flush_i))
	else $error("instr_queue: push into a full queue");

// Decode only pops a head it was shown
assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> head_vld_o)
	else $error("instr_queue: pop from an empty queue");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f rv_decode.f \
	--top-module tb_rv_decode -o tb_rv_decode_sim || exit 1
./obj_dir/tb_rv_decode_sim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

//--- rv_decode.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
decode/instr_queue.sv
decode/decode_table.sv
decode/decode_register.sv
src/rv_decode_top.sv
tb/tb_rv_decode.sv

//--- src/rv_decode_top.sv
// RV32I decode stage
// Instruction queue, decode table and decode register

`timescale 1ns/100ps

`include "rv_decode_params.svh"

module rv_decode_top
	import rv_ctrl_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      fetch_vld_i,
	input  logic [`RV_XLEN-1:0]       fetch_instr_i,
	input  logic                      fetch_err_i,
	input  logic                      jump_i,
	input  logic [`RV_XLEN-1:0]       jump_target_i,
	input  logic                      x_stall_i,
	output logic                      d_vld_o,
	output logic [`RV_XLEN-1:0]       d_pc_o,
	output logic [`RV_REGADDR_W-1:0]  d_rs1_o,
	output logic [`RV_REGADDR_W-1:0]  d_rs2_o,
	output logic [`RV_REGADDR_W-1:0]  d_rd_o,
	output logic [`RV_XLEN-1:0]       d_imm_o,
	output alu_op_t                   d_alu_op_o,
	output alu_src_a_t                d_alu_src_a_o,
	output alu_src_b_t                d_alu_src_b_o,
	output mem_op_t                   d_mem_op_o,
	output branch_cond_t              d_branch_cond_o,
	output logic [`RV_XLEN-1:0]       d_addr_offs_o,
	output logic                      d_addr_is_regoffs_o,
	output except_t                   d_except_o
);

// Queue head
logic [`RV_XLEN-1:0]      q_instr;
logic                     q_err;
logic                     q_vld;
logic                     q_pop;

// Unregistered decode of the head
logic [`RV_REGADDR_W-1:0] t_rs1, t_rs2, t_rd;
logic [`RV_XLEN-1:0]      t_imm, t_addr_offs;
alu_op_t                  t_alu_op;
alu_src_a_t               t_alu_src_a;
alu_src_b_t               t_alu_src_b;
mem_op_t                  t_mem_op;
branch_cond_t             t_branch_cond;
logic                     t_addr_is_regoffs;
except_t                  t_except;
logic                     t_illegal;

instr_queue #(.DEPTH(`RV_QUEUE_DEPTH)) u_queue (
	.clk, .rst_n,
	.push_i (fetch_vld_i), .instr_i (fetch_instr_i), .err_i (fetch_err_i),
	.pop_i  (q_pop), .flush_i (jump_i),
	.head_instr_o (q_instr), .head_err_o (q_err), .head_vld_o (q_vld)
);

decode_table u_table (
	.instr_i (q_instr),
	.rs1_o (t_rs1), .rs2_o (t_rs2), .rd_o (t_rd), .imm_o (t_imm),
	.alu_op_o (t_alu_op), .alu_src_a_o (t_alu_src_a), .alu_src_b_o (t_alu_src_b),
	.mem_op_o (t_mem_op), .branch_cond_o (t_branch_cond),
	.addr_offs_o (t_addr_offs), .addr_is_regoffs_o (t_addr_is_regoffs),
	.except_o (t_except), .illegal_o (t_illegal)
);

decode_register u_reg (
	.clk, .rst_n,
	.q_instr_vld_i (q_vld), .q_err_i (q_err), .x_stall_i, .jump_i, .jump_target_i,
	.rs1_i (t_rs1), .rs2_i (t_rs2), .rd_i (t_rd), .imm_i (t_imm),
	.alu_op_i (t_alu_op), .alu_src_a_i (t_alu_src_a), .alu_src_b_i (t_alu_src_b),
	.mem_op_i (t_mem_op), .branch_cond_i (t_branch_cond),
	.addr_offs_i (t_addr_offs), .addr_is_regoffs_i (t_addr_is_regoffs),
	.except_i (t_except), .illegal_i (t_illegal),
	.q_pop_o (q_pop), .d_vld_o, .d_pc_o, .d_rs1_o, .d_rs2_o, .d_rd_o, .d_imm_o,
	.d_alu_op_o, .d_alu_src_a_o, .d_alu_src_b_o, .d_mem_op_o, .d_branch_cond_o,
	.d_addr_offs_o, .d_addr_is_regoffs_o, .d_except_o
);

endmodule

//--- tb/rv_decode_testdata.txt
# instr err rs1 rs2 rd imm alu_op src_a src_b mem_op branch_cond addr_offs except jump target
# All hex, enum columns hold rv_ctrl_pkg encodings, jump loads target as this word's PC
002081b3 0 01 02 03 00000002 0 0 0 0 0 00000000 0 0 00000000
407302b3 0 06 07 05 00000407 1 0 0 0 0 00000000 0 0 00000000
40a4d433 0 09 0a 08 0000040a 7 0 0 0 0 00000000 0 0 00000000
00d635b3 0 0c 0d 0b 0000000d 4 0 0 0 0 00000000 0 0 00000000
ffb10093 0 02 00 01 fffffffb 0 0 1 0 0 00000000 0 0 00000000
0ff2c213 0 05 00 04 000000ff 5 0 1 0 0 00000000 0 0 00000000
4033d313 0 07 00 06 00000403 7 0 1 0 0 00000000 0 0 00000000
12345537 0 00 00 0a 12345000 a 0 1 0 0 00000000 0 0 00000000
abcde597 0 00 00 0b abcde000 0 1 1 0 0 00000000 0 0 00000000
ff86a603 0 0d 00 0c fffffff8 0 0 0 3 0 fffffff8 0 0 00000000
0047c703 0 0f 00 0e 00000004 0 0 0 4 0 00000004 0 0 00000000
01089323 0 11 10 00 00000010 a 0 0 7 0 00000006 0 1 00001000
fe2088e3 0 01 02 00 ffffffe2 1 0 0 0 1 fffffff0 0 0 00000000
0041e463 0 03 04 00 00000004 4 0 0 0 2 00000008 0 0 00000000
001000ef 0 00 00 01 00000004 0 1 1 0 3 00000800 0 0 00000000
00c28067 0 05 00 00 00000004 0 1 1 0 3 0000000c 0 0 00000000
0ff0000f 0 00 00 00 000000ff 0 0 0 0 0 00000000 0 0 00000000
00000073 0 00 00 00 00000000 0 0 0 0 0 00000000 3 0 00000000
00100073 0 00 00 00 00000001 0 0 0 0 0 00000000 4 1 80000040
ffffffff 0 00 00 00 00000000 0 0 0 0 0 00000000 2 0 00000000
002081b3 1 00 00 00 00000000 0 0 0 0 0 00000000 1 0 00000000
00013083 0 00 00 00 00000000 0 0 0 0 0 00000000 2 0 00000000
ffffffff 1 00 00 00 00000000 0 0 0 0 0 00000000 1 0 00000000
002081b3 0 01 02 03 00000002 0 0 0 0 0 00000000 0 0 00000000

//--- tb/tb_rv_decode.sv
// Testbench for the RV32I decode stage
// Replays the test data file under random execute stalls and models the PC

`timescale 1ns/100ps

`include "rv_decode_params.svh"

module tb_rv_decode
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
();

localparam int WAIT_LIMIT = 200;
localparam int NUM_COLS   = 15;

// One decoded word as execute should see it
typedef struct packed {
	int                       idx;
	logic [`RV_XLEN-1:0]      pc;
	logic [`RV_REGADDR_W-1:0] rs1;
	logic [`RV_REGADDR_W-1:0] rs2;
	logic [`RV_REGADDR_W-1:0] rd;
	logic [`RV_XLEN-1:0]      imm;
	alu_op_t                  alu_op;
	alu_src_a_t               src_a;
	alu_src_b_t               src_b;
	mem_op_t                  mem_op;
	branch_cond_t             bcond;
	logic [`RV_XLEN-1:0]      addr_offs;
	logic                     regoffs;
	except_t                  exc;
} exp_rec_t;

logic                     clk;
logic                     rst_n;
logic                     fetch_vld_i;
logic [`RV_XLEN-1:0]      fetch_instr_i;
logic                     fetch_err_i;
logic                     jump_i;
logic [`RV_XLEN-1:0]      jump_target_i;
logic                     x_stall_i;
logic                     d_vld_o;
logic [`RV_XLEN-1:0]      d_pc_o;
logic [`RV_REGADDR_W-1:0] d_rs1_o;
logic [`RV_REGADDR_W-1:0] d_rs2_o;
logic [`RV_REGADDR_W-1:0] d_rd_o;
logic [`RV_XLEN-1:0]      d_imm_o;
alu_op_t                  d_alu_op_o;
alu_src_a_t               d_alu_src_a_o;
alu_src_b_t               d_alu_src_b_o;
mem_op_t                  d_mem_op_o;
branch_cond_t             d_branch_cond_o;
logic [`RV_XLEN-1:0]      d_addr_offs_o;
logic                     d_addr_is_regoffs_o;
except_t                  d_except_o;

exp_rec_t    exp_q[$];
exp_rec_t    head;
int          outstanding;
int          n_words;
int          n_seen;
logic [31:0] rng;

rv_decode_top dut (.*);

always #10 clk = ~clk;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// ------------------------------------------------------------
// Failure reporting and compares

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("Verification failed");
	$fatal(1, "stopped at the first error");
endtask

task automatic report_mismatch(input string what, input string got_s, input string exp_s);
	abort_run($sformatf("Mismatch at time %0t: %s is %s, expected %s",
		$time, what, got_s, exp_s));
endtask

task automatic word_eq(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
		input string what);
	if (got !== exp)
		report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic regaddr_eq(input logic [`RV_REGADDR_W-1:0] got,
		input logic [`RV_REGADDR_W-1:0] exp, input string what);
	if (got !== exp)
		report_mismatch(what, $sformatf("x%0d", got), $sformatf("x%0d", exp));
endtask

task automatic flag_eq(input logic got, input logic exp, input string what);
	if (got !== exp)
		report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic alu_op_eq(input alu_op_t got, input alu_op_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic src_a_eq(input alu_src_a_t got, input alu_src_a_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic src_b_eq(input alu_src_b_t got, input alu_src_b_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic mem_op_eq(input mem_op_t got, input mem_op_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic bcond_eq(input branch_cond_t got, input branch_cond_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic except_eq(input except_t got, input except_t exp, input string what);
	if (got !== exp)
		report_mismatch(what, got.name(), exp.name());
endtask

task automatic check_decoded(input exp_rec_t e);
	string w;
	w = $sformatf("word %0d", e.idx);
	word_eq(d_pc_o, e.pc, {w, " pc"});
	regaddr_eq(d_rs1_o, e.rs1, {w, " rs1"});
	regaddr_eq(d_rs2_o, e.rs2, {w, " rs2"});
	regaddr_eq(d_rd_o, e.rd, {w, " rd"});
	mem_op_eq(d_mem_op_o, e.mem_op, {w, " mem_op"});
	bcond_eq(d_branch_cond_o, e.bcond, {w, " branch_cond"});
	except_eq(d_except_o, e.exc, {w, " except"});
	// Fault and illegal words only define registers, memory op, branch and exception
	if (e.exc != EXCEPT_INSTR_FAULT && e.exc != EXCEPT_INSTR_ILLEGAL) begin
		word_eq(d_imm_o, e.imm, {w, " imm"});
		alu_op_eq(d_alu_op_o, e.alu_op, {w, " alu_op"});
		src_a_eq(d_alu_src_a_o, e.src_a, {w, " alu_src_a"});
		src_b_eq(d_alu_src_b_o, e.src_b, {w, " alu_src_b"});
		word_eq(d_addr_offs_o, e.addr_offs, {w, " addr_offs"});
		flag_eq(d_addr_is_regoffs_o, e.regoffs, {w, " addr_is_regoffs"});
	end
endtask

// One falling edge with idle fetch and a random stall
task automatic next_cycle();
	@(negedge clk);
	rng           = xorshift32(rng);
	fetch_vld_i   = 1'b0;
	jump_i        = 1'b0;
	x_stall_i     = rng[1:0] == 2'b00;
endtask

task automatic wait_for_room();
	int cycles;
	cycles = 0;
	while (outstanding >= `RV_QUEUE_DEPTH) begin
		if (cycles == WAIT_LIMIT) begin
			abort_run("Timeout: the queue never drained to accept the next word");
		end else begin
			next_cycle();
			cycles++;
		end
	end
endtask

// ------------------------------------------------------------
// Output monitor

always @(posedge clk) begin
	if (rst_n && d_vld_o) begin
		if (x_stall_i) begin
			abort_run("d_vld_o fired while x_stall_i was high");
		end else if (exp_q.size() == 0) begin
			abort_run("d_vld_o fired although no word was outstanding");
		end else begin
			head = exp_q.pop_front();
			check_decoded(head);
			outstanding--;
			n_seen++;
		end
	end
end

// ------------------------------------------------------------
// Stimulus

initial begin
	int                  fd;
	int                  cnt;
	int                  cycles;
	string               line;
	logic [31:0]         col [NUM_COLS];
	exp_rec_t            rec;
	logic [`RV_XLEN-1:0] next_pc;

	clk           = 1'b0;
	rst_n         = 1'b0;
	fetch_vld_i   = 1'b0;
	fetch_instr_i = '0;
	fetch_err_i   = 1'b0;
	jump_i        = 1'b0;
	jump_target_i = '0;
	x_stall_i     = 1'b0;
	rng           = 32'hbdada84d;
	outstanding   = 0;
	n_words       = 0;
	n_seen        = 0;
	next_pc       = `RV_RESET_VECTOR;

	repeat (4) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
	if (d_vld_o !== 1'b0)
		abort_run("d_vld_o is not low after reset");
	word_eq(d_pc_o, `RV_RESET_VECTOR, "pc after reset");
	mem_op_eq(d_mem_op_o, MEMOP_NONE, "mem_op after reset");
	bcond_eq(d_branch_cond_o, BCOND_NEVER, "branch_cond after reset");
	except_eq(d_except_o, EXCEPT_NONE, "except after reset");

	fd = $fopen("tb/rv_decode_testdata.txt", "r");
	if (fd == 0)
		abort_run("Could not open the test data file tb/rv_decode_testdata.txt");

	while (!$feof(fd)) begin
		cnt = $fgets(line, fd);
		if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
			if (cnt != NUM_COLS)
				abort_run($sformatf("Test data line for word %0d is malformed", n_words));
			rng = xorshift32(rng);
			repeat (rng[0]) next_cycle();
			wait_for_room();
			next_cycle();

			fetch_vld_i   = 1'b1;
			fetch_instr_i = col[0];
			fetch_err_i   = col[1][0];
			// A jump empties the pipe and this word starts the new stream
			if (col[13][0]) begin
				jump_i        = 1'b1;
				jump_target_i = col[14];
				exp_q.delete();
				outstanding = 0;
				next_pc     = col[14];
			end

			rec.idx       = n_words;
			rec.pc        = next_pc;
			rec.rs1       = col[2][`RV_REGADDR_W-1:0];
			rec.rs2       = col[3][`RV_REGADDR_W-1:0];
			rec.rd        = col[4][`RV_REGADDR_W-1:0];
			rec.imm       = col[5];
			rec.alu_op    = alu_op_t'(col[6][3:0]);
			rec.src_a     = alu_src_a_t'(col[7][0]);
			rec.src_b     = alu_src_b_t'(col[8][0]);
			rec.mem_op    = mem_op_t'(col[9][3:0]);
			rec.bcond     = branch_cond_t'(col[10][1:0]);
			rec.addr_offs = col[11];
			// Loads, stores and JALR form their address from rs1
			rec.regoffs   = col[0][6:0] inside {OPC_LOAD, OPC_STORE, OPC_JALR};
			rec.exc       = except_t'(col[12][2:0]);
			exp_q.push_back(rec);
			outstanding++;
			n_words++;
			next_pc = next_pc + `RV_XLEN'(4);
		end
	end
	$fclose(fd);

	next_cycle();
	cycles = 0;
	while (exp_q.size() != 0) begin
		if (cycles == WAIT_LIMIT) begin
			abort_run("Timeout: decoded words stopped arriving");
		end else begin
			next_cycle();
			cycles++;
		end
	end

	if (n_words == 0) begin
		abort_run("The test data file holds no instruction words");
	end else begin
		$display("Verification passed");
		$finish;
	end
end

endmodule
